// File: hw/secp256k1_pkg.sv
/* secp256k1 field definitions */

package secp256k1_pkg;

  typedef logic [255:0] fe_t;    // Field element mod p
  typedef logic [511:0] prod_t;  // Full product before reduction
  typedef logic [5:0]   tag_t;   // Equation number riding with a multiply
  typedef logic [32:0]  fold_t;  // Width of the fold constant

  // Equations in the point-add schedule
  localparam int N_EQ = 24;

  // One bit per equation
  typedef logic [N_EQ-1:0] eq_mask_t;

  // p = 2^256 - 2^32 - 977
  localparam fe_t P_MOD = {
    64'hFFFF_FFFF_FFFF_FFFF,
    64'hFFFF_FFFF_FFFF_FFFF,
    64'hFFFF_FFFF_FFFF_FFFF,
    64'hFFFF_FFFE_FFFF_FC2F
  };

  // 2^256 mod p, folds the upper half back onto the lower half
  localparam fold_t FOLD_C = 33'h1_0000_03D1;

endpackage

// File: hw/secp256k1_mult_stage.sv
/* Tagged 256x256 multiply stage */

`timescale 1ns/1ps

module secp256k1_mult_stage #(
  parameter int P_MULT_LAT = 2  // Register depth, at least 1
) (
  input  logic                  i_clk,
  input  logic                  i_rst,
  // Operands from the adder
  input  secp256k1_pkg::fe_t    i_a,
  input  secp256k1_pkg::fe_t    i_b,
  input  secp256k1_pkg::tag_t   i_tag,
  input  logic                  i_val,
  output logic                  o_rdy,
  // Raw product towards the reduction
  output secp256k1_pkg::prod_t  o_prod,
  output secp256k1_pkg::tag_t   o_tag,
  output logic                  o_val,
  input  logic                  i_rdy
);

  logic [P_MULT_LAT-1:0]  val_q;                  // Slot occupied
  secp256k1_pkg::prod_t   prod_q [P_MULT_LAT];    // Product shift line
  secp256k1_pkg::tag_t    tag_q  [P_MULT_LAT];
  logic                   adv;                    // Whole line moves one slot

  // Move when the last slot is free or is being drained
  assign adv   = ~val_q[P_MULT_LAT-1] | i_rdy;
  assign o_rdy = adv;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      val_q <= '0;
    end else if (adv) begin
      for (int i = P_MULT_LAT - 1; i > 0; i--) begin
        val_q[i] <= val_q[i-1];
      end
      val_q[0] <= i_val;
    end
  end

  // Multiply up front; the trailing registers let synthesis retime it
  always_ff @(posedge i_clk) begin
    if (adv) begin
      prod_q[0] <= secp256k1_pkg::prod_t'(i_a) * secp256k1_pkg::prod_t'(i_b);
      tag_q[0]  <= i_tag;
      for (int i = 1; i < P_MULT_LAT; i++) begin
        prod_q[i] <= prod_q[i-1];
        tag_q[i]  <= tag_q[i-1];
      end
    end
  end

  assign o_prod = prod_q[P_MULT_LAT-1];
  assign o_tag  = tag_q[P_MULT_LAT-1];
  assign o_val  = val_q[P_MULT_LAT-1];

  // A stalled product must not change under the reduce stage
  a_hold_on_stall: assert property (
    @(posedge i_clk) disable iff (i_rst)
    o_val && !i_rdy |=> o_val && $stable(o_prod) && $stable(o_tag)
  );

endmodule

// File: hw/secp256k1_reduce_stage.sv
/* Fold reduction modulo p */

`timescale 1ns/1ps

module secp256k1_reduce_stage (
  input  logic                  i_clk,
  input  logic                  i_rst,
  // Raw product from the multiply stage
  input  secp256k1_pkg::prod_t  i_prod,
  input  secp256k1_pkg::tag_t   i_tag,
  input  logic                  i_val,
  output logic                  o_rdy,
  // Reduced result back to the adder
  output secp256k1_pkg::fe_t    o_res,
  output secp256k1_pkg::tag_t   o_tag,
  output logic                  o_val,
  input  logic                  i_rdy
);

  // First fold: H*C + L < 2^256 * (2^32 + 978), so 290 bits
  typedef logic [289:0] fold1_t;
  // Second fold: below 2^256 + 2^66
  typedef logic [256:0] fold2_t;

  localparam fold2_t P_WIDE = fold2_t'(secp256k1_pkg::P_MOD);

  fold1_t               fold1_d, fold1_q;
  fold2_t               fold2, sub1, sub2;
  secp256k1_pkg::tag_t  tag1_q, tag2_q;
  secp256k1_pkg::fe_t   res_q;
  logic                 val1_q, val2_q;
  logic                 adv;

  // Both stages freeze together when the output is held
  assign adv   = ~val2_q | i_rdy;
  assign o_rdy = adv;

  // Fold once
  always_comb begin
    fold1_d = fold1_t'(i_prod[511:256]) * fold1_t'(secp256k1_pkg::FOLD_C)
            + fold1_t'(i_prod[255:0]);
  end

  // Fold twice, then at most two subtractions of p
  always_comb begin
    fold2 = fold2_t'(fold1_q[289:256]) * fold2_t'(secp256k1_pkg::FOLD_C)
          + fold2_t'(fold1_q[255:0]);
    sub1  = (fold2 >= P_WIDE) ? fold2 - P_WIDE : fold2;
    sub2  = (sub1 >= P_WIDE) ? sub1 - P_WIDE : sub1;  // Second one only after a 2^256 carry
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      val1_q <= 1'b0;
      val2_q <= 1'b0;
    end else if (adv) begin
      val1_q <= i_val;
      val2_q <= val1_q;
    end
  end

  always_ff @(posedge i_clk) begin
    if (adv) begin
      fold1_q <= fold1_d;
      tag1_q  <= i_tag;
      res_q   <= sub2[255:0];
      tag2_q  <= tag1_q;
    end
  end

  assign o_res = res_q;
  assign o_tag = tag2_q;
  assign o_val = val2_q;

  // Fully reduced whenever presented
  a_res_below_p: assert property (
    @(posedge i_clk) disable iff (i_rst)
    o_val |-> (o_res < secp256k1_pkg::P_MOD)
  );

endmodule

// File: hw/secp256k1_point_add.sv
/* Jacobian point adder with equation scheduler */

`timescale 1ns/1ps

module secp256k1_point_add (
  input  logic                 i_clk,
  input  logic                 i_rst,
  // Input points
  input  secp256k1_pkg::fe_t   i_p1_x,
  input  secp256k1_pkg::fe_t   i_p1_y,
  input  secp256k1_pkg::fe_t   i_p1_z,
  input  secp256k1_pkg::fe_t   i_p2_x,
  input  secp256k1_pkg::fe_t   i_p2_y,
  input  secp256k1_pkg::fe_t   i_p2_z,
  input  logic                 i_val,
  output logic                 o_rdy,
  // Sum
  output secp256k1_pkg::fe_t   o_p_x,
  output secp256k1_pkg::fe_t   o_p_y,
  output secp256k1_pkg::fe_t   o_p_z,
  output logic                 o_val,
  output logic                 o_err,
  input  logic                 i_rdy,
  // Multiplier requests
  output secp256k1_pkg::fe_t   o_mul_a,
  output secp256k1_pkg::fe_t   o_mul_b,
  output secp256k1_pkg::tag_t  o_mul_tag,
  output logic                 o_mul_val,
  input  logic                 i_mul_rdy,
  // Reduced products
  input  secp256k1_pkg::fe_t   i_res,
  input  secp256k1_pkg::tag_t  i_res_tag,
  input  logic                 i_res_val,
  output logic                 o_res_rdy
);

  typedef enum logic [1:0] {IDLE, COMPUTE, DONE} state_t;

  // Finished equations each step waits on
  localparam secp256k1_pkg::eq_mask_t DEP [secp256k1_pkg::N_EQ] = '{
    24'h000000,  // 0  A = Z2^2
    24'h000001,  // 1  X1 = A*X1            U1
    24'h000000,  // 2  C = Z1^2
    24'h000004,  // 3  X2 = C*X2            U2
    24'h000002,  // 4  A = A*Z2
    24'h000010,  // 5  A = A*Y1             S1
    24'h000008,  // 6  C = C*Z1
    24'h000040,  // 7  C = C*Y2             S2
    24'h00002A,  // 8  Y1 = X2 - X1         H, after Y1 is consumed
    24'h0000A0,  // 9  Y2 = C - A           R
    24'h000200,  // 10 OX = Y2^2            R^2
    24'h000300,  // 11 C = Y1^2             H^2
    24'h000900,  // 12 X2 = C*Y1            H^3
    24'h001400,  // 13 OX = OX - X2
    24'h000900,  // 14 X1 = X1*C            U1*H^2
    24'h004000,  // 15 OY = X1
    24'h00C000,  // 16 X1 = 2*X1
    24'h012000,  // 17 OX = OX - X1         X3
    24'h028000,  // 18 OY = OY - OX
    24'h040200,  // 19 OY = OY*Y2
    24'h003020,  // 20 X2 = X2*A            S1*H^3, after step 13 read H^3
    24'h180000,  // 21 OY = OY - X2         Y3
    24'h000000,  // 22 OZ = Z1*Z2
    24'h400100   // 23 OZ = OZ*Y1           Z3
  };

  // Steps that go to the multiplier; the rest finish in one cycle here
  localparam secp256k1_pkg::eq_mask_t MUL_MASK = 24'hD85CFF;

  state_t                   state_q;
  secp256k1_pkg::eq_mask_t  iss_q, fin_q;         // Issued / finished per equation
  secp256k1_pkg::eq_mask_t  rdy_eq, cand, sel_hot, res_hot, alu_fire;
  secp256k1_pkg::tag_t      sel_tag;
  secp256k1_pkg::fe_t       p1x, p1y, p1z, p2x, p2y, p2z;  // Latched points, reused as scratch
  secp256k1_pkg::fe_t       a_q, c_q;            // Temporaries
  secp256k1_pkg::fe_t       op_a, op_b;
  logic                     sel_any, computing, accept, issue_fire;
  logic                     res_issued, res_known, res_good, res_bad;
  logic                     inf_in, x_eq, y_eq;

  // Subtract mod p, adding p first when b is larger
  function automatic secp256k1_pkg::fe_t sub_mod(input secp256k1_pkg::fe_t a,
                                                 input secp256k1_pkg::fe_t b);
    return a + ((b > a) ? secp256k1_pkg::P_MOD : '0) - b;
  endfunction

  // 2a mod p
  function automatic secp256k1_pkg::fe_t dbl_mod(input secp256k1_pkg::fe_t a);
    logic [256:0] s;
    s = {1'b0, a} + {1'b0, a};
    if (s >= {1'b0, secp256k1_pkg::P_MOD}) s = s - {1'b0, secp256k1_pkg::P_MOD};
    return s[255:0];
  endfunction

  assign computing = (state_q == COMPUTE);
  assign accept    = (state_q == IDLE) && i_val && o_rdy;
  assign inf_in    = (i_p1_z == '0) || (i_p2_z == '0);
  assign x_eq      = (i_p1_x == i_p2_x);
  assign y_eq      = (i_p1_y == i_p2_y);
  assign o_res_rdy = 1'b1;  // Never back-pressure; results outside COMPUTE are dropped

  // Ready steps and the lowest-numbered ready multiply
  always_comb begin
    sel_tag = '0;
    sel_any = 1'b0;
    sel_hot = '0;
    for (int i = 0; i < secp256k1_pkg::N_EQ; i++) begin
      rdy_eq[i] = ((fin_q & DEP[i]) == DEP[i]) && !iss_q[i];
    end
    cand = rdy_eq & MUL_MASK;
    for (int i = secp256k1_pkg::N_EQ - 1; i >= 0; i--) begin
      if (cand[i]) begin
        sel_tag = secp256k1_pkg::tag_t'(i);
        sel_any = 1'b1;
        sel_hot = '0;
        sel_hot[i] = 1'b1;
      end
    end
  end

  assign issue_fire = computing && sel_any && (!o_mul_val || i_mul_rdy);
  assign alu_fire   = computing ? (rdy_eq & ~MUL_MASK) : '0;

  // Operand select for the chosen multiply
  always_comb begin
    case (sel_tag)
      0:       begin op_a = p2z;   op_b = p2z; end
      1:       begin op_a = a_q;   op_b = p1x; end
      2:       begin op_a = p1z;   op_b = p1z; end
      3:       begin op_a = c_q;   op_b = p2x; end
      4:       begin op_a = a_q;   op_b = p2z; end
      5:       begin op_a = a_q;   op_b = p1y; end
      6:       begin op_a = c_q;   op_b = p1z; end
      7:       begin op_a = c_q;   op_b = p2y; end
      10:      begin op_a = p2y;   op_b = p2y; end
      11:      begin op_a = p1y;   op_b = p1y; end
      12:      begin op_a = c_q;   op_b = p1y; end
      14:      begin op_a = c_q;   op_b = p1x; end
      19:      begin op_a = o_p_y; op_b = p2y; end
      20:      begin op_a = p2x;   op_b = a_q; end
      22:      begin op_a = p1z;   op_b = p2z; end
      23:      begin op_a = o_p_z; op_b = p1y; end
      default: begin op_a = '0;    op_b = '0;  end
    endcase
  end

  // Classify a returning tag
  always_comb begin
    res_issued = 1'b0;
    res_known  = 1'b0;
    res_hot    = '0;
    for (int i = 0; i < secp256k1_pkg::N_EQ; i++) begin
      if (i_res_tag == secp256k1_pkg::tag_t'(i)) begin
        res_issued = iss_q[i];
        res_known  = iss_q[i] && !fin_q[i] && MUL_MASK[i];
        res_hot[i] = 1'b1;
      end
    end
  end

  assign res_good = computing && i_res_val && res_known;
  assign res_bad  = computing && i_res_val && !res_known;

  // Control
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state_q   <= IDLE;
      o_rdy     <= 1'b0;
      o_val     <= 1'b0;
      o_err     <= 1'b0;
      o_mul_val <= 1'b0;
      iss_q     <= '0;
      fin_q     <= '0;
    end else begin
      if (o_mul_val && i_mul_rdy) o_mul_val <= 1'b0;
      if (issue_fire) o_mul_val <= 1'b1;
      case (state_q)
        IDLE: begin
          if (accept) begin
            o_rdy   <= 1'b0;
            iss_q   <= '0;
            fin_q   <= '0;
            state_q <= COMPUTE;
            if (inf_in || x_eq) begin  // Infinity operand, opposite or identical points
              state_q <= DONE;
              o_val   <= 1'b1;
              o_err   <= !inf_in && y_eq;  // Doubling not supported
            end
          end else begin
            o_rdy <= 1'b1;
          end
        end
        COMPUTE: begin
          iss_q <= iss_q | alu_fire | (issue_fire ? sel_hot : '0);
          fin_q <= fin_q | alu_fire | (res_good ? res_hot : '0);
          if (&fin_q || res_bad) begin
            state_q <= DONE;
            o_val   <= 1'b1;
            o_err   <= res_bad;
          end
        end
        DONE: begin
          if (i_rdy) begin  // Output taken
            state_q <= IDLE;
            o_val   <= 1'b0;
            o_err   <= 1'b0;
            o_rdy   <= 1'b1;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Datapath registers
  always_ff @(posedge i_clk) begin
    if (accept) begin
      p1x <= i_p1_x;
      p1y <= i_p1_y;
      p1z <= i_p1_z;
      p2x <= i_p2_x;
      p2y <= i_p2_y;
      p2z <= i_p2_z;
      o_p_x <= '0;  // Infinity unless passed through
      o_p_y <= '0;
      o_p_z <= '0;
      if (i_p1_z == '0) begin
        o_p_x <= i_p2_x;
        o_p_y <= i_p2_y;
        o_p_z <= i_p2_z;
      end else if (i_p2_z == '0) begin
        o_p_x <= i_p1_x;
        o_p_y <= i_p1_y;
        o_p_z <= i_p1_z;
      end
    end
    if (issue_fire) begin
      o_mul_a   <= op_a;
      o_mul_b   <= op_b;
      o_mul_tag <= sel_tag;
    end
    if (res_good) begin
      case (i_res_tag)
        0, 4, 5:      a_q   <= i_res;
        1, 14:        p1x   <= i_res;
        2, 6, 7, 11:  c_q   <= i_res;
        3, 12, 20:    p2x   <= i_res;
        10:           o_p_x <= i_res;
        19:           o_p_y <= i_res;
        22, 23:       o_p_z <= i_res;
        default:      ;
      endcase
    end
    // In-module steps, never two on the same register in one cycle
    if (alu_fire[8])  p1y   <= sub_mod(p2x, p1x);
    if (alu_fire[9])  p2y   <= sub_mod(c_q, a_q);
    if (alu_fire[13]) o_p_x <= sub_mod(o_p_x, p2x);
    if (alu_fire[15]) o_p_y <= p1x;  // Keep U1*H^2 before it is doubled
    if (alu_fire[16]) p1x   <= dbl_mod(p1x);
    if (alu_fire[17]) o_p_x <= sub_mod(o_p_x, p1x);
    if (alu_fire[18]) o_p_y <= sub_mod(o_p_y, o_p_x);
    if (alu_fire[21]) o_p_y <= sub_mod(o_p_y, p2x);
  end

  // Every product coming back was requested in this run
  a_tag_issued: assert property (
    @(posedge i_clk) disable iff (i_rst)
    i_res_val && computing |-> res_issued
  );

endmodule

// File: hw/secp256k1_point_add_top.sv
/* Point adder with multiplier pipeline */

`timescale 1ns/1ps

module secp256k1_point_add_top #(
  parameter int P_MULT_LAT = 2  // Multiply stage depth
) (
  input  logic                i_clk,
  input  logic                i_rst,
  input  secp256k1_pkg::fe_t  i_p1_x,
  input  secp256k1_pkg::fe_t  i_p1_y,
  input  secp256k1_pkg::fe_t  i_p1_z,
  input  secp256k1_pkg::fe_t  i_p2_x,
  input  secp256k1_pkg::fe_t  i_p2_y,
  input  secp256k1_pkg::fe_t  i_p2_z,
  input  logic                i_val,
  output logic                o_rdy,
  output secp256k1_pkg::fe_t  o_p_x,
  output secp256k1_pkg::fe_t  o_p_y,
  output secp256k1_pkg::fe_t  o_p_z,
  output logic                o_val,
  output logic                o_err,
  input  logic                i_rdy
);

  // Adder to multiply stage
  secp256k1_pkg::fe_t    mul_a, mul_b;
  secp256k1_pkg::tag_t   mul_tag;
  logic                  mul_val, mul_rdy;
  // Multiply stage to reduce stage
  secp256k1_pkg::prod_t  prod;
  secp256k1_pkg::tag_t   prod_tag;
  logic                  prod_val, prod_rdy;
  // Reduce stage back to adder
  secp256k1_pkg::fe_t    res;
  secp256k1_pkg::tag_t   res_tag;
  logic                  res_val, res_rdy;

  secp256k1_point_add u_point_add (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_p1_x    (i_p1_x),
    .i_p1_y    (i_p1_y),
    .i_p1_z    (i_p1_z),
    .i_p2_x    (i_p2_x),
    .i_p2_y    (i_p2_y),
    .i_p2_z    (i_p2_z),
    .i_val     (i_val),
    .o_rdy     (o_rdy),
    .o_p_x     (o_p_x),
    .o_p_y     (o_p_y),
    .o_p_z     (o_p_z),
    .o_val     (o_val),
    .o_err     (o_err),
    .i_rdy     (i_rdy),
    .o_mul_a   (mul_a),
    .o_mul_b   (mul_b),
    .o_mul_tag (mul_tag),
    .o_mul_val (mul_val),
    .i_mul_rdy (mul_rdy),
    .i_res     (res),
    .i_res_tag (res_tag),
    .i_res_val (res_val),
    .o_res_rdy (res_rdy)
  );

  secp256k1_mult_stage #(
    .P_MULT_LAT (P_MULT_LAT)
  ) u_mult_stage (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_a    (mul_a),
    .i_b    (mul_b),
    .i_tag  (mul_tag),
    .i_val  (mul_val),
    .o_rdy  (mul_rdy),
    .o_prod (prod),
    .o_tag  (prod_tag),
    .o_val  (prod_val),
    .i_rdy  (prod_rdy)
  );

  secp256k1_reduce_stage u_reduce_stage (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_prod (prod),
    .i_tag  (prod_tag),
    .i_val  (prod_val),
    .o_rdy  (prod_rdy),
    .o_res  (res),
    .o_tag  (res_tag),
    .o_val  (res_val),
    .i_rdy  (res_rdy)
  );

endmodule

// File: tb/tb_clkgen.sv
/* Testbench clock and reset */

`timescale 1ns/1ps

module tb_clkgen #(
  parameter int CLK_PERIOD = 20,  // ns
  parameter int RST_CYCLES = 3
) (
  output logic o_clk,
  output logic o_rst
);

  initial begin
    o_clk = 1'b0;
    forever #(CLK_PERIOD / 2) o_clk = ~o_clk;
  end

  // Synchronous reset, released on a rising edge
  initial begin
    o_rst = 1'b1;
    repeat (RST_CYCLES) @(posedge o_clk);
    o_rst <= 1'b0;
  end

endmodule

// File: tb/tb_point_add.sv
/* Point adder directed tests */

`timescale 1ns/1ps

module tb_point_add;

  localparam int CLK_PERIOD = 20;
  localparam int N_TESTS    = 6;     // Sets the watchdog budget
  localparam int WAIT_MAX   = 2000;  // Cycles allowed per handshake
  localparam secp256k1_pkg::fe_t P = secp256k1_pkg::P_MOD;

  // Generator G and 2G, affine
  localparam secp256k1_pkg::fe_t G_X  =
    256'h79BE667EF9DCBBAC55A06295CE870B07029BFCDB2DCE28D959F2815B16F81798;
  localparam secp256k1_pkg::fe_t G_Y  =
    256'h483ADA7726A3C4655DA4FBFC0E1108A8FD17B448A68554199C47D08FFB10D4B8;
  localparam secp256k1_pkg::fe_t G2_X =
    256'hC6047F9441ED7D6D3045406E95C07CD85C778E4B8CEF3CA7ABAC09B95C709EE5;
  localparam secp256k1_pkg::fe_t G2_Y =
    256'h1AE168FEA63DC339A3C58419466CEAEEF7F632653266D0E1236431A950CFE52A;

  logic                clk, rst;
  secp256k1_pkg::fe_t  p1_x, p1_y, p1_z, p2_x, p2_y, p2_z;
  secp256k1_pkg::fe_t  p_x, p_y, p_z;
  logic                in_val, in_rdy, out_rdy, out_val, out_err;
  int                  err_cnt, check_cnt, test_cnt;

  tb_clkgen #(.CLK_PERIOD(CLK_PERIOD), .RST_CYCLES(3)) u_clkgen (.o_clk(clk), .o_rst(rst));

  secp256k1_point_add_top #(
    .P_MULT_LAT (2)
  ) UUT (
    .i_clk  (clk),
    .i_rst  (rst),
    .i_p1_x (p1_x),
    .i_p1_y (p1_y),
    .i_p1_z (p1_z),
    .i_p2_x (p2_x),
    .i_p2_y (p2_y),
    .i_p2_z (p2_z),
    .i_val  (in_val),
    .o_rdy  (out_rdy),
    .o_p_x  (p_x),
    .o_p_y  (p_y),
    .o_p_z  (p_z),
    .o_val  (out_val),
    .o_err  (out_err),
    .i_rdy  (in_rdy)
  );

  // Field arithmetic for the reference model
  function automatic secp256k1_pkg::fe_t mod_mul(input secp256k1_pkg::fe_t a,
                                                 input secp256k1_pkg::fe_t b);
    secp256k1_pkg::prod_t t;
    t = (secp256k1_pkg::prod_t'(a) * secp256k1_pkg::prod_t'(b)) % secp256k1_pkg::prod_t'(P);
    return t[255:0];
  endfunction

  function automatic secp256k1_pkg::fe_t mod_sub(input secp256k1_pkg::fe_t a,
                                                 input secp256k1_pkg::fe_t b);
    logic [256:0] t;
    t = ({1'b0, a} + {1'b0, P} - {1'b0, b}) % {1'b0, P};
    return t[255:0];
  endfunction

  // Uniform-ish value below p
  function automatic secp256k1_pkg::fe_t rand_fe();
    secp256k1_pkg::fe_t v;
    for (int i = 0; i < 8; i++) v[32*i +: 32] = $urandom();
    if (v >= P) v = v - P;  // 2^256 - p is tiny
    return v;
  endfunction

  // Jacobian addition, formulas U1 through Z3
  task automatic ref_add(input secp256k1_pkg::fe_t x1, y1, z1, x2, y2, z2,
                         output secp256k1_pkg::fe_t x3, y3, z3);
    secp256k1_pkg::fe_t z1s, z2s, u1, u2, s1, s2, h, r, h2, h3, u1h2;
    z1s  = mod_mul(z1, z1);
    z2s  = mod_mul(z2, z2);
    u1   = mod_mul(x1, z2s);
    u2   = mod_mul(x2, z1s);
    s1   = mod_mul(y1, mod_mul(z2s, z2));
    s2   = mod_mul(y2, mod_mul(z1s, z1));
    h    = mod_sub(u2, u1);
    r    = mod_sub(s2, s1);
    h2   = mod_mul(h, h);
    h3   = mod_mul(h2, h);
    u1h2 = mod_mul(u1, h2);
    x3   = mod_sub(mod_sub(mod_sub(mod_mul(r, r), h3), u1h2), u1h2);  // R^2 - H^3 - 2U1H^2
    y3   = mod_sub(mod_mul(r, mod_sub(u1h2, x3)), mod_mul(s1, h3));
    z3   = mod_mul(mod_mul(z1, z2), h);
  endtask

  task automatic compare_fe(input string name, input secp256k1_pkg::fe_t got,
                            input secp256k1_pkg::fe_t exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic note_error(input string what);
    err_cnt++;
    $display("error: %s", what);
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_cnt++;
    $display("test %s: %s", name, (err_cnt == errs_before) ? "ok" : "FAILED");
  endtask

  // Present both points and hold until accepted
  task automatic send_points(input secp256k1_pkg::fe_t x1, y1, z1, x2, y2, z2);
    int n;
    n = 0;
    @(posedge clk);
    p1_x   <= x1;
    p1_y   <= y1;
    p1_z   <= z1;
    p2_x   <= x2;
    p2_y   <= y2;
    p2_z   <= z2;
    in_val <= 1'b1;
    @(negedge clk);
    while (!out_rdy && n < WAIT_MAX) begin  // Transfer on the edge after o_rdy is seen
      @(negedge clk);
      n++;
    end
    if (!out_rdy) note_error("adder never raised o_rdy for the inputs");
    @(posedge clk);
    in_val <= 1'b0;
  endtask

  // Sample the sum mid-cycle once o_val is up
  task automatic wait_result(output secp256k1_pkg::fe_t rx, ry, rz, output logic rerr,
                             output logic ok);
    int n;
    n = 0;
    @(negedge clk);
    while (!out_val && n < WAIT_MAX) begin
      @(negedge clk);
      n++;
    end
    ok   = out_val;
    rx   = p_x;
    ry   = p_y;
    rz   = p_z;
    rerr = out_err;
    if (!ok) note_error("no o_val within the wait limit");
  endtask

  // Full add through the DUT, checked against the formulas
  task automatic add_and_check(input secp256k1_pkg::fe_t x1, y1, z1, x2, y2, z2);
    secp256k1_pkg::fe_t ex, ey, ez, rx, ry, rz;
    logic rerr, ok;
    ref_add(x1, y1, z1, x2, y2, z2, ex, ey, ez);
    send_points(x1, y1, z1, x2, y2, z2);
    wait_result(rx, ry, rz, rerr, ok);
    if (ok) begin
      compare_fe("o_p_x", rx, ex);
      compare_fe("o_p_y", ry, ey);
      compare_fe("o_p_z", rz, ez);
      compare_bit("o_err", rerr, 1'b0);
    end
  endtask

  task automatic pass_infinity();
    secp256k1_pkg::fe_t ax, ay, az, bx, by, bz, rx, ry, rz;
    logic rerr, ok;
    int e0;
    e0 = err_cnt;
    ax = rand_fe();
    ay = rand_fe();
    az = rand_fe() | 256'h1;  // Any nonzero Z
    bx = rand_fe();
    by = rand_fe();
    bz = rand_fe() | 256'h1;
    send_points(ax, ay, '0, bx, by, bz);  // P1 at infinity, expect P2
    wait_result(rx, ry, rz, rerr, ok);
    if (ok) begin
      compare_fe("o_p_x", rx, bx);
      compare_fe("o_p_y", ry, by);
      compare_fe("o_p_z", rz, bz);
      compare_bit("o_err", rerr, 1'b0);
    end
    send_points(ax, ay, az, bx, by, '0);  // And the mirror case
    wait_result(rx, ry, rz, rerr, ok);
    if (ok) begin
      compare_fe("o_p_x", rx, ax);
      compare_fe("o_p_y", ry, ay);
      compare_fe("o_p_z", rz, az);
      compare_bit("o_err", rerr, 1'b0);
    end
    report_test("infinity operand", e0);
  endtask

  task automatic cancel_opposite();
    secp256k1_pkg::fe_t x, ya, yb, rx, ry, rz;
    logic rerr, ok;
    int e0;
    e0 = err_cnt;
    x  = rand_fe();
    ya = rand_fe();
    yb = mod_sub('0, ya);
    if (yb == ya) yb = ya ^ 256'h2;  // Keep the y words distinct
    send_points(x, ya, 256'h1, x, yb, 256'h1);
    wait_result(rx, ry, rz, rerr, ok);
    if (ok) begin
      compare_fe("o_p_x", rx, '0);
      compare_fe("o_p_y", ry, '0);
      compare_fe("o_p_z", rz, '0);
      compare_bit("o_err", rerr, 1'b0);
    end
    report_test("opposite points", e0);
  endtask

  task automatic reject_identical();
    secp256k1_pkg::fe_t rx, ry, rz;
    logic rerr, ok;
    int e0;
    e0 = err_cnt;
    send_points(G_X, G_Y, 256'h1, G_X, G_Y, 256'h1);  // Would need doubling
    wait_result(rx, ry, rz, rerr, ok);
    compare_bit("o_val", ok, 1'b1);
    compare_bit("o_err", rerr, 1'b1);
    add_and_check(G_X, G_Y, 256'h1, G2_X, G2_Y, 256'h1);  // Recovers cleanly
    report_test("identical points", e0);
  endtask

  task automatic sum_g_and_2g();
    int e0;
    e0 = err_cnt;
    add_and_check(G_X, G_Y, 256'h1, G2_X, G2_Y, 256'h1);
    report_test("G plus 2G", e0);
  endtask

  task automatic sum_random();
    secp256k1_pkg::fe_t x1, y1, z1, x2, y2, z2;
    int e0;
    e0 = err_cnt;
    for (int i = 0; i < 20; i++) begin
      x1 = rand_fe();
      y1 = rand_fe();
      x2 = rand_fe();
      y2 = rand_fe();
      do z1 = rand_fe(); while (z1 == '0);
      do z2 = rand_fe(); while (z2 == '0);
      while (x2 == x1) x2 = rand_fe();
      add_and_check(x1, y1, z1, x2, y2, z2);
    end
    report_test("random operands", e0);
  endtask

  task automatic stall_output();
    secp256k1_pkg::fe_t x1, y1, z1, x2, y2, z2, ex, ey, ez, rx, ry, rz;
    logic rerr, ok;
    int e0, k;
    e0 = err_cnt;
    x1 = rand_fe();
    y1 = rand_fe();
    z1 = rand_fe() | 256'h1;
    x2 = x1 ^ 256'h4;  // Distinct x words
    y2 = rand_fe();
    z2 = rand_fe() | 256'h1;
    k  = 5 + ($urandom() % 26);
    ref_add(x1, y1, z1, x2, y2, z2, ex, ey, ez);
    @(posedge clk);
    in_rdy <= 1'b0;
    send_points(x1, y1, z1, x2, y2, z2);
    wait_result(rx, ry, rz, rerr, ok);
    if (ok) begin
      compare_fe("o_p_x", rx, ex);
      compare_fe("o_p_y", ry, ey);
      compare_fe("o_p_z", rz, ez);
      compare_bit("o_err", rerr, 1'b0);
      repeat (k) begin  // Output must sit still while stalled
        @(negedge clk);
        compare_bit("o_val", out_val, 1'b1);
        compare_fe("o_p_x", p_x, ex);
        compare_fe("o_p_y", p_y, ey);
        compare_fe("o_p_z", p_z, ez);
      end
    end
    @(posedge clk);
    in_rdy <= 1'b1;
    @(posedge clk);  // Handshake edge
    @(negedge clk);
    compare_bit("o_val", out_val, 1'b0);
    compare_bit("o_rdy", out_rdy, 1'b1);
    report_test("back-pressure", e0);
  endtask

  // Main sequence
  initial begin
    void'($urandom(45570));
    in_val    = 1'b0;
    in_rdy    = 1'b1;
    p1_x      = '0;
    p1_y      = '0;
    p1_z      = '0;
    p2_x      = '0;
    p2_y      = '0;
    p2_z      = '0;
    err_cnt   = 0;
    check_cnt = 0;
    test_cnt  = 0;
    @(negedge clk);
    while (rst) @(negedge clk);
    pass_infinity();
    cancel_opposite();
    reject_identical();
    sum_g_and_2g();
    sum_random();
    stall_output();
    $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(N_TESTS * WAIT_MAX * CLK_PERIOD);
    $display("error: watchdog expired before the tests finished");
    $display("Done: errors found");
    $finish;
  end

endmodule

// File: all.f
hw/secp256k1_pkg.sv
hw/secp256k1_mult_stage.sv
hw/secp256k1_reduce_stage.sv
hw/secp256k1_point_add.sv
hw/secp256k1_point_add_top.sv
tb/tb_clkgen.sv
tb/tb_point_add.sv

// File: Bender.yml
package:
  name: secp256k1_point_add

sources:
  # Design
  - files:
      - hw/secp256k1_pkg.sv
      - hw/secp256k1_mult_stage.sv
      - hw/secp256k1_reduce_stage.sv
      - hw/secp256k1_point_add.sv
      - hw/secp256k1_point_add_top.sv
  # Testbench
  - target: test
    files:
      - tb/tb_clkgen.sv
      - tb/tb_point_add.sv
